// File: sources.f
logic/mpu_bus_pkg.sv
logic/mpu_periph_pkg.sv
logic/periph_bus_if.sv
logic/mpu_bus_bridge.sv
logic/mpu_interval_timer.sv
logic/mpu_interrupt_ctrl.sv
logic/mpu_top.sv
bench/mpu_properties.sv
bench/mpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench, a failing run returns a nonzero status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module mpu_tb -o mpu_sim

./obj_dir/mpu_sim

// File: bench/mpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_tb;

	localparam int TIMER_W = 32;
	// cycles any single wait may take
	localparam int TIMEOUT = 200;
	localparam logic [31:0] TIMER_PAGE = {mpu_bus_pkg::TIMER_BASE, 12'h000};
	localparam logic [31:0] PIC_PAGE = {mpu_bus_pkg::PIC_BASE, 12'h000};
	// timer registers sit on lanes, the lane rebuilds address bits 3:2
	localparam int T_RELOAD = int'(mpu_periph_pkg::RELOAD);
	localparam int T_COUNT = int'(mpu_periph_pkg::COUNT);
	localparam int T_CONTROL = int'(mpu_periph_pkg::CONTROL);
	localparam int P_PENDING = int'(mpu_periph_pkg::PENDING);
	localparam int P_ENABLE = int'(mpu_periph_pkg::ENABLE);
	localparam int P_LEVEL0 = int'(mpu_periph_pkg::LEVEL0);
	localparam int P_LEVEL1 = int'(mpu_periph_pkg::LEVEL1);
	localparam int P_LEVEL2 = int'(mpu_periph_pkg::LEVEL2);
	localparam int P_LEVEL3 = int'(mpu_periph_pkg::LEVEL3);

	logic clk_i;
	logic reset_i;
	logic core_cyc_i;
	logic core_stb_i;
	logic core_we_i;
	logic [15:0] core_sel_i;
	logic [31:0] core_adr_i;
	logic [127:0] core_dat_i;
	logic core_ack_o;
	logic [127:0] core_dat_o;
	logic ext_cyc_o;
	logic ext_stb_o;
	logic ext_we_o;
	logic [15:0] ext_sel_o;
	logic [31:0] ext_adr_o;
	logic [127:0] ext_dat_o;
	logic ext_ack_i;
	logic [127:0] ext_dat_i;
	logic [27:0] irq_src_i;
	logic nmi_i;
	logic [2:0] irq_o;
	logic [7:0] cause_o;
	logic nmi_o;
	logic tick3_o;

	// external memory model and the last request it saw
	logic [127:0] ext_mem [logic [31:0]];
	logic [31:0] last_adr;
	logic [15:0] last_sel;
	logic [127:0] last_dat;
	logic last_we;

	mpu_top #(
		.TIMER_W(TIMER_W)
	) u_mpu_top (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.core_cyc_i(core_cyc_i),
		.core_stb_i(core_stb_i),
		.core_we_i(core_we_i),
		.core_sel_i(core_sel_i),
		.core_adr_i(core_adr_i),
		.core_dat_i(core_dat_i),
		.core_ack_o(core_ack_o),
		.core_dat_o(core_dat_o),
		.ext_cyc_o(ext_cyc_o),
		.ext_stb_o(ext_stb_o),
		.ext_we_o(ext_we_o),
		.ext_sel_o(ext_sel_o),
		.ext_adr_o(ext_adr_o),
		.ext_dat_o(ext_dat_o),
		.ext_ack_i(ext_ack_i),
		.ext_dat_i(ext_dat_i),
		.irq_src_i(irq_src_i),
		.nmi_i(nmi_i),
		.irq_o(irq_o),
		.cause_o(cause_o),
		.nmi_o(nmi_o),
		.tick3_o(tick3_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// ========================================
	// helpers
	// ========================================

	// unwritten memory, every address bit shows up in the word
	function automatic logic [127:0] fill_word(input logic [31:0] adr);
		return {adr, ~adr, adr ^ 32'h5ca1_ab1e, {adr[15:0], adr[31:16]}};
	endfunction

	function automatic logic [127:0] merge_bytes(input logic [127:0] old,
		input logic [127:0] wdat, input logic [15:0] sel);
		logic [127:0] res;
		res = old;
		for (int b = 0; b < 16; b++) begin
			if (sel[b]) begin
				res[b*8 +: 8] = wdat[b*8 +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [31:0] timer_adr(input int ch);
		return TIMER_PAGE | 32'(ch << 4);
	endfunction

	// register index bit 2 goes to address bit 4, bits 1:0 pick the lane
	function automatic logic [31:0] pic_adr(input int idx);
		return PIC_PAGE | 32'((idx >> 2) << 4);
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s: got %0h expected %0h", name, got, exp));
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_i);
			#1;
		end
	endtask

	// ========================================
	// external responder
	// ========================================

	// acks 1 to 4 cycles after it sees stb, holds ack for one cycle
	initial begin : ext_responder
		int delay;
		ext_ack_i = 1'b0;
		ext_dat_i = '0;
		delay = 0;
		forever begin
			@(posedge clk_i);
			#1;
			if (ext_ack_i) begin
				ext_ack_i = 1'b0;
				ext_dat_i = '0;
			end else if (ext_cyc_o && ext_stb_o) begin
				if (delay == 0) begin
					delay = int'($urandom_range(4, 1));
				end
				delay--;
				if (delay == 0) begin
					if (!ext_mem.exists(ext_adr_o)) begin
						ext_mem[ext_adr_o] = fill_word(ext_adr_o);
					end
					last_adr = ext_adr_o;
					last_sel = ext_sel_o;
					last_dat = ext_dat_o;
					last_we = ext_we_o;
					if (ext_we_o) begin
						ext_mem[ext_adr_o] = merge_bytes(ext_mem[ext_adr_o], ext_dat_o, ext_sel_o);
					end else begin
						ext_dat_i = ext_mem[ext_adr_o];
					end
					ext_ack_i = 1'b1;
				end
			end
		end
	end

	// ========================================
	// core bus tasks
	// ========================================

	// starts and ends 1 ns after a rising edge
	task automatic bus_access(input logic we, input logic [31:0] adr, input logic [15:0] sel,
		input logic [127:0] wdat, output logic [127:0] rdat, output int cycles);
		cycles = 0;
		core_cyc_i = 1'b1;
		core_stb_i = 1'b1;
		core_we_i = we;
		core_sel_i = sel;
		core_adr_i = adr;
		core_dat_i = wdat;
		do begin
			@(posedge clk_i);
			#1;
			cycles++;
		end while (!core_ack_o && cycles < TIMEOUT);
		if (!core_ack_o) begin
			fail_run($sformatf("no ack from the bridge for address %h", adr));
		end
		rdat = core_dat_o;
		core_cyc_i = 1'b0;
		core_stb_i = 1'b0;
		core_we_i = 1'b0;
		// idle cycle so the bridge drops its hold before the next request
		wait_cycles(1);
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [15:0] sel,
		input logic [127:0] wdat, output int cycles);
		logic [127:0] unused_dat;
		bus_access(1'b1, adr, sel, wdat, unused_dat, cycles);
	endtask

	task automatic bus_read(input logic [31:0] adr, input logic [15:0] sel,
		output logic [127:0] rdat, output int cycles);
		bus_access(1'b0, adr, sel, '0, rdat, cycles);
	endtask

	// noise on the other lanes, the bridge must pick the selected one
	task automatic reg_write(input logic [31:0] adr, input int lane, input logic [31:0] val);
		logic [127:0] wdat;
		int cycles;
		wdat = {$urandom(), $urandom(), $urandom(), $urandom()};
		wdat[32*lane +: 32] = val;
		bus_write(adr, 16'hF << (4 * lane), wdat, cycles);
		check("peripheral write latency", 128'(cycles), 128'(3));
	endtask

	// read data comes back on all four lanes
	task automatic reg_check(input string name, input logic [31:0] adr, input int lane,
		input logic [31:0] exp);
		logic [127:0] rdat;
		int cycles;
		bus_read(adr, 16'hF << (4 * lane), rdat, cycles);
		check("peripheral read latency", 128'(cycles), 128'(3));
		check(name, rdat, {4{exp}});
	endtask

	task automatic pic_write(input int idx, input logic [31:0] val);
		reg_write(pic_adr(idx), idx % 4, val);
	endtask

	task automatic pic_check(input string name, input int idx, input logic [31:0] exp);
		reg_check(name, pic_adr(idx), idx % 4, exp);
	endtask

	task automatic check_irq(input logic [2:0] level, input logic [7:0] cause);
		check("irq_o", 128'(irq_o), 128'(level));
		check("cause_o", 128'(cause_o), 128'(cause));
	endtask

	// ========================================
	// directed tests
	// ========================================

	task automatic test_ext_bus();
		logic [31:0] adr;
		logic [15:0] sel;
		logic [127:0] wdat;
		logic [127:0] rdat;
		int cycles;
		for (int i = 0; i < 8; i++) begin
			// fresh aligned address per pass, never on an on-chip page
			adr = ($urandom() & 32'hFFFF_F000) | 32'(i << 4);
			if (adr[31:12] == mpu_bus_pkg::TIMER_BASE || adr[31:12] == mpu_bus_pkg::PIC_BASE) begin
				adr[31] = 1'b0;
			end
			sel = 16'($urandom());
			wdat = {$urandom(), $urandom(), $urandom(), $urandom()};
			bus_write(adr, sel, wdat, cycles);
			check("ext_adr_o", 128'(last_adr), 128'(adr));
			check("ext_sel_o", 128'(last_sel), 128'(sel));
			check("ext_dat_o", last_dat, wdat);
			check("ext_we_o", 128'(last_we), 128'(1));
			// one cycle from ext ack to core ack, responder waits 1 to 4
			check("ext write latency in range", 128'(cycles >= 2 && cycles <= 5), 128'(1));
			bus_read(adr, 16'hFFFF, rdat, cycles);
			check("ext_we_o", 128'(last_we), 128'(0));
			check("core_dat_o", rdat, merge_bytes(fill_word(adr), wdat, sel));
		end
	endtask

	task automatic test_timer_regs();
		logic [31:0] rel;
		logic [127:0] rdat;
		int cycles;
		for (int ch = 0; ch < 4; ch++) begin
			rel = 32'(32'h100 * (ch + 1)) + ($urandom() & 32'hFF);
			reg_write(timer_adr(ch), T_RELOAD, rel);
			// auto only, counter holds still
			reg_write(timer_adr(ch), T_CONTROL, 32'h2);
			reg_check("timer reload", timer_adr(ch), T_RELOAD, rel);
			reg_check("timer count", timer_adr(ch), T_COUNT, rel);
			reg_check("timer control", timer_adr(ch), T_CONTROL, 32'h2);
			reg_check("timer unused register", timer_adr(ch), 3, 32'h0);
			// no lane selected falls back to lane 0
			bus_read(timer_adr(ch), 16'h0000, rdat, cycles);
			check("timer reload on default lane", rdat, {4{rel}});
		end
	endtask

	task automatic test_timer_period();
		int n;
		int reload;
		reload = 5;
		reg_write(timer_adr(3), T_RELOAD, 32'(reload));
		reg_write(timer_adr(3), T_CONTROL, 32'h3);
		n = 0;
		while (!tick3_o && n < TIMEOUT) begin
			wait_cycles(1);
			n++;
		end
		if (!tick3_o) begin
			fail_run("tick3_o never pulsed with channel 3 enabled");
		end
		for (int p = 0; p < 3; p++) begin
			n = 0;
			do begin
				wait_cycles(1);
				n++;
			end while (!tick3_o && n < TIMEOUT);
			check("tick3_o period", 128'(n), 128'(reload + 1));
		end
		reg_write(timer_adr(3), T_CONTROL, 32'h0);
	endtask

	task automatic test_pic_priority();
		// source 5 lvl 3, 10 lvl 6, 12 lvl 2, 20 lvl 6, 31 lvl 7
		pic_write(P_LEVEL0, 32'h0030_0000);
		pic_write(P_LEVEL1, 32'h0002_0600);
		pic_write(P_LEVEL2, 32'h0006_0000);
		pic_write(P_LEVEL3, 32'h7000_0000);
		pic_check("level1", P_LEVEL1, 32'h0002_0600);
		pic_check("level3", P_LEVEL3, 32'h7000_0000);
		pic_write(P_ENABLE, 32'h0010_1420);
		pic_check("enable", P_ENABLE, 32'h0010_1420);
		check_irq(3'd0, 8'd0);
		// source s sits on irq_src_i[s-1]
		irq_src_i[4] = 1'b1;
		irq_src_i[11] = 1'b1;
		// pending one cycle later, irq one more
		wait_cycles(2);
		check_irq(3'd3, 8'd5);
		irq_src_i[9] = 1'b1;
		irq_src_i[19] = 1'b1;
		wait_cycles(2);
		// 10 and 20 tie at 6, higher source wins
		check_irq(3'd6, 8'd20);
		pic_check("pending", P_PENDING, 32'h0010_1420);
		pic_write(P_PENDING, 32'h0010_0000);
		check_irq(3'd6, 8'd10);
	endtask

	task automatic test_pic_mask();
		int n;
		irq_src_i = '0;
		pic_write(P_PENDING, 32'hFFFF_FFFF);
		check_irq(3'd0, 8'd0);
		// source 3 at level 7 but left masked
		pic_write(P_LEVEL0, 32'h0030_7000);
		irq_src_i[2] = 1'b1;
		wait_cycles(2);
		check_irq(3'd0, 8'd0);
		pic_check("masked pending", P_PENDING, 32'h0000_0008);
		pic_write(P_PENDING, 32'h0000_0008);
		irq_src_i[2] = 1'b0;
		// timer channel 0 drives source 31
		pic_write(P_ENABLE, 32'h8000_0000);
		reg_write(timer_adr(0), T_RELOAD, 32'h3);
		reg_write(timer_adr(0), T_CONTROL, 32'h1);
		n = 0;
		while (cause_o != 8'd31 && n < TIMEOUT) begin
			wait_cycles(1);
			n++;
		end
		if (cause_o != 8'd31) begin
			fail_run("timer channel 0 never raised cause 31");
		end
		check_irq(3'd7, 8'd31);
		pic_write(P_PENDING, 32'h8000_0000);
		check_irq(3'd0, 8'd0);
		// nmi is registered once
		nmi_i = 1'b1;
		check("nmi_o before edge", 128'(nmi_o), 128'(0));
		wait_cycles(1);
		check("nmi_o", 128'(nmi_o), 128'(1));
		nmi_i = 1'b0;
		wait_cycles(1);
		check("nmi_o", 128'(nmi_o), 128'(0));
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin : main
		void'($urandom(32'h700e));
		reset_i = 1'b1;
		core_cyc_i = 1'b0;
		core_stb_i = 1'b0;
		core_we_i = 1'b0;
		core_sel_i = '0;
		core_adr_i = '0;
		core_dat_i = '0;
		irq_src_i = '0;
		nmi_i = 1'b0;
		repeat (10) @(posedge clk_i);
		#1;
		reset_i = 1'b0;
		check("ext_cyc_o after reset", 128'(ext_cyc_o), 128'(0));
		check("ext_stb_o after reset", 128'(ext_stb_o), 128'(0));
		check("core_ack_o after reset", 128'(core_ack_o), 128'(0));
		check("nmi_o after reset", 128'(nmi_o), 128'(0));
		check("tick3_o after reset", 128'(tick3_o), 128'(0));
		check_irq(3'd0, 8'd0);
		test_ext_bus();
		test_timer_regs();
		test_timer_period();
		test_pic_priority();
		test_pic_mask();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/mpu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_properties (
	input logic clk_i,
	input logic reset_i,
	input logic core_stb_i,
	input logic core_ack_i,
	input logic ext_stb_i,
	input logic [mpu_bus_pkg::ADDR_W-1:0] ext_adr_i,
	input logic [mpu_bus_pkg::CORE_SEL_W-1:0] ext_sel_i,
	input logic [mpu_bus_pkg::LANES-1:0] lane_hot_i
);

	localparam int PAGE_W = mpu_bus_pkg::PAGE_W;
	localparam int AW = mpu_bus_pkg::ADDR_W;
	localparam int LSW = mpu_bus_pkg::LANE_SEL_W;

	logic onchip_page;
	logic [mpu_bus_pkg::CORE_SEL_W-1:0] lane_mask;

	// page match on the registered address, independent of the bridge decode
	assign onchip_page = ext_adr_i[AW-1 -: PAGE_W] == mpu_bus_pkg::TIMER_BASE
		|| ext_adr_i[AW-1 -: PAGE_W] == mpu_bus_pkg::PIC_BASE;

	// selects covered by the chosen lane
	always_comb begin
		lane_mask = '0;
		for (int l = 0; l < mpu_bus_pkg::LANES; l++) begin
			lane_mask[l*LSW +: LSW] = {LSW{lane_hot_i[l]}};
		end
	end

	// one ack per request, the core has let go of stb by then
	a_ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
		core_ack_i && !core_stb_i |=> !core_ack_i)
		else $error("core ack held for a second cycle after stb dropped");

	// on-chip pages never leak onto the external bus
	a_no_ext_stb: assert property (@(posedge clk_i) disable iff (reset_i)
		onchip_page |-> !ext_stb_i)
		else $error("external stb raised for an on-chip peripheral page");

	// exactly one lane, and it carries a select unless none is set
	a_one_lane: assert property (@(posedge clk_i) disable iff (reset_i)
		$onehot(lane_hot_i)
		&& ((ext_sel_i == '0) ? lane_hot_i[0] : |(ext_sel_i & lane_mask)))
		else $error("lane narrowing picked other than exactly one selected lane");

endmodule

bind mpu_bus_bridge mpu_properties u_properties (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.core_stb_i(core_stb_i),
	.core_ack_i(core_ack_o),
	.ext_stb_i(ext_stb_o),
	.ext_adr_i(ext_adr_o),
	.ext_sel_i(ext_sel_o),
	.lane_hot_i(lane_hot)
);

`default_nettype wire

// File: logic/mpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_top #(
	parameter int TIMER_W = 32
) (
	input  logic clk_i,
	input  logic reset_i,
	// core side
	input  logic core_cyc_i,
	input  logic core_stb_i,
	input  logic core_we_i,
	input  logic [mpu_bus_pkg::CORE_SEL_W-1:0] core_sel_i,
	input  logic [mpu_bus_pkg::ADDR_W-1:0] core_adr_i,
	input  logic [mpu_bus_pkg::CORE_DATA_W-1:0] core_dat_i,
	output logic core_ack_o,
	output logic [mpu_bus_pkg::CORE_DATA_W-1:0] core_dat_o,
	// external bus
	output logic ext_cyc_o,
	output logic ext_stb_o,
	output logic ext_we_o,
	output logic [mpu_bus_pkg::CORE_SEL_W-1:0] ext_sel_o,
	output logic [mpu_bus_pkg::ADDR_W-1:0] ext_adr_o,
	output logic [mpu_bus_pkg::CORE_DATA_W-1:0] ext_dat_o,
	input  logic ext_ack_i,
	input  logic [mpu_bus_pkg::CORE_DATA_W-1:0] ext_dat_i,
	// interrupts and timer
	input  logic [mpu_periph_pkg::EXT_IRQ_W-1:0] irq_src_i,
	input  logic nmi_i,
	output logic [mpu_periph_pkg::IRQ_LEVEL_W-1:0] irq_o,
	output logic [mpu_periph_pkg::CAUSE_W-1:0] cause_o,
	output logic nmi_o,
	output logic tick3_o
);

	logic [mpu_periph_pkg::TIMER_CHANNELS-1:0] tick;
	logic [mpu_periph_pkg::IRQ_SOURCES-1:0] irq_src;

	periph_bus_if timer_bus ();
	periph_bus_if pic_bus ();

	mpu_bus_bridge u_bridge (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.core_cyc_i(core_cyc_i),
		.core_stb_i(core_stb_i),
		.core_we_i(core_we_i),
		.core_sel_i(core_sel_i),
		.core_adr_i(core_adr_i),
		.core_dat_i(core_dat_i),
		.core_ack_o(core_ack_o),
		.core_dat_o(core_dat_o),
		.ext_cyc_o(ext_cyc_o),
		.ext_stb_o(ext_stb_o),
		.ext_we_o(ext_we_o),
		.ext_sel_o(ext_sel_o),
		.ext_adr_o(ext_adr_o),
		.ext_dat_o(ext_dat_o),
		.ext_ack_i(ext_ack_i),
		.ext_dat_i(ext_dat_i),
		.timer_bus(timer_bus.bridge),
		.pic_bus(pic_bus.bridge)
	);

	mpu_interval_timer #(
		.TIMER_W(TIMER_W)
	) u_timer (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.bus(timer_bus.periph),
		.tick_o(tick)
	);

	// source 0 unused so cause 0 means nothing pending,
	// ticks 0..2 sit on the top sources in reverse order
	assign irq_src = {tick[0], tick[1], tick[2], irq_src_i, 1'b0};

	mpu_interrupt_ctrl u_pic (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.bus(pic_bus.periph),
		.src_i(irq_src),
		.nmi_i(nmi_i),
		.irq_o(irq_o),
		.cause_o(cause_o),
		.nmi_o(nmi_o)
	);

	assign tick3_o = tick[3];

endmodule

`default_nettype wire

// File: logic/mpu_interrupt_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_interrupt_ctrl (
	input  logic clk_i,
	input  logic reset_i,
	periph_bus_if.periph bus,
	input  logic [mpu_periph_pkg::IRQ_SOURCES-1:0] src_i,
	input  logic nmi_i,
	output logic [mpu_periph_pkg::IRQ_LEVEL_W-1:0] irq_o,
	output logic [mpu_periph_pkg::CAUSE_W-1:0] cause_o,
	output logic nmi_o
);

	localparam int SRC = mpu_periph_pkg::IRQ_SOURCES;
	localparam int LW = mpu_periph_pkg::IRQ_LEVEL_W;
	localparam int CW = mpu_periph_pkg::CAUSE_W;
	localparam int NF = mpu_periph_pkg::LEVEL_FIELDS;
	localparam int FW = mpu_periph_pkg::LEVEL_FIELD_W;
	localparam int DW = mpu_bus_pkg::PERIPH_DATA_W;

	logic req;
	logic wr_stb;
	logic ack_q;
	logic [DW-1:0] rd_dat;
	logic [DW-1:0] dat_r_q;
	mpu_periph_pkg::pic_reg_e reg_sel;
	logic is_level;
	logic [1:0] grp;
	logic [SRC-1:0] src_q;
	logic [SRC-1:0] rise;
	logic [SRC-1:0] clr_mask;
	logic [SRC-1:0] pending_q;
	logic [SRC-1:0] enable_q;
	logic [SRC-1:0][LW-1:0] lvl_q;
	logic [LW-1:0] best_lvl;
	logic [CW-1:0] best_src;

	assign req = bus.pic_cs & bus.cyc & bus.stb;
	assign wr_stb = req & ~ack_q & bus.we;
	assign reg_sel = mpu_periph_pkg::pic_reg_e'(
		bus.adr[mpu_periph_pkg::PIC_REG_LSB +: mpu_periph_pkg::PIC_REG_W]);

	// which group of eight sources a LEVEL register covers
	always_comb begin
		is_level = 1'b1;
		grp = 2'd0;
		case (reg_sel)
			mpu_periph_pkg::LEVEL0: grp = 2'd0;
			mpu_periph_pkg::LEVEL1: grp = 2'd1;
			mpu_periph_pkg::LEVEL2: grp = 2'd2;
			mpu_periph_pkg::LEVEL3: grp = 2'd3;
			default: is_level = 1'b0;
		endcase
	end

	// ======================================
	// sources and registers
	// ======================================

	assign rise = src_i & ~src_q;
	// write ones to PENDING to clear
	assign clr_mask = (wr_stb && reg_sel == mpu_periph_pkg::PENDING) ? bus.dat_w : '0;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			src_q <= '0;
			pending_q <= '0;
			enable_q <= '0;
			lvl_q <= '0;
		end else begin
			src_q <= src_i;
			// a new edge beats a clear in the same cycle
			pending_q <= (pending_q & ~clr_mask) | rise;
			if (wr_stb && reg_sel == mpu_periph_pkg::ENABLE) begin
				enable_q <= bus.dat_w;
			end
			if (wr_stb && is_level) begin
				for (int i = 0; i < NF; i++) begin
					lvl_q[grp*NF + i] <= bus.dat_w[i*FW +: LW];
				end
			end
		end
	end

	// ======================================
	// priority resolve
	// ======================================

	// ascending scan with >= so the higher source takes a tie
	always_comb begin
		best_lvl = '0;
		best_src = '0;
		for (int i = 0; i < SRC; i++) begin
			if (pending_q[i] && enable_q[i] && lvl_q[i] >= best_lvl) begin
				best_lvl = lvl_q[i];
				best_src = i[CW-1:0];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			irq_o <= '0;
			cause_o <= '0;
			nmi_o <= 1'b0;
		end else begin
			irq_o <= best_lvl;
			cause_o <= best_src;
			nmi_o <= nmi_i;
		end
	end

	// ======================================
	// read back and ack
	// ======================================

	always_comb begin
		rd_dat = '0;
		if (is_level) begin
			for (int i = 0; i < NF; i++) begin
				rd_dat[i*FW +: LW] = lvl_q[grp*NF + i];
			end
		end else if (reg_sel == mpu_periph_pkg::PENDING) begin
			rd_dat[SRC-1:0] = pending_q;
		end else if (reg_sel == mpu_periph_pkg::ENABLE) begin
			rd_dat[SRC-1:0] = enable_q;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
			dat_r_q <= '0;
		end else begin
			ack_q <= req & ~ack_q;
			dat_r_q <= (req & ~ack_q) ? rd_dat : '0;
		end
	end

	assign bus.ack = ack_q;
	assign bus.dat_r = dat_r_q;

endmodule

`default_nettype wire

// File: logic/mpu_interval_timer.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_interval_timer #(
	parameter int TIMER_W = 32
) (
	input  logic clk_i,
	input  logic reset_i,
	periph_bus_if.periph bus,
	output logic [mpu_periph_pkg::TIMER_CHANNELS-1:0] tick_o
);

	localparam int CH = mpu_periph_pkg::TIMER_CHANNELS;
	localparam int CHW = mpu_periph_pkg::TIMER_CHAN_W;
	localparam int CTW = mpu_periph_pkg::TIMER_CTRL_W;
	localparam int EN = mpu_periph_pkg::TIMER_CTRL_ENABLE;
	localparam int AUTO = mpu_periph_pkg::TIMER_CTRL_AUTO;
	localparam int DW = mpu_bus_pkg::PERIPH_DATA_W;

	logic req;
	logic wr_stb;
	logic ack_q;
	logic [DW-1:0] rd_dat;
	logic [DW-1:0] dat_r_q;
	logic [CHW-1:0] chan;
	mpu_periph_pkg::timer_reg_e reg_sel;
	logic [CH-1:0][TIMER_W-1:0] reload_v;
	logic [CH-1:0][TIMER_W-1:0] count_v;
	logic [CH-1:0][CTW-1:0] ctrl_v;

	assign req = bus.timer_cs & bus.cyc & bus.stb;
	// write takes effect once, on the cycle the ack is raised
	assign wr_stb = req & ~ack_q & bus.we;
	assign chan = bus.adr[mpu_periph_pkg::TIMER_CHAN_LSB +: CHW];
	assign reg_sel = mpu_periph_pkg::timer_reg_e'(
		bus.adr[mpu_periph_pkg::TIMER_REG_LSB +: mpu_periph_pkg::TIMER_REG_W]);

	// ======================================
	// channels
	// ======================================

	for (genvar ch = 0; ch < CH; ch++) begin : g_chan
		logic [TIMER_W-1:0] reload_q;
		logic [TIMER_W-1:0] count_q;
		logic [CTW-1:0] ctrl_q;
		logic tick_q;
		logic sel_ch;
		logic load;
		logic expire;

		assign sel_ch = wr_stb && chan == CHW'(ch);
		// RELOAD and COUNT writes both load the counter
		assign load = sel_ch && (reg_sel == mpu_periph_pkg::RELOAD
			|| reg_sel == mpu_periph_pkg::COUNT);
		assign expire = ctrl_q[EN] && count_q == '0 && !load;

		always_ff @(posedge clk_i) begin
			if (sel_ch && reg_sel == mpu_periph_pkg::RELOAD) begin
				reload_q <= bus.dat_w[TIMER_W-1:0];
			end
		end

		always_ff @(posedge clk_i) begin
			if (reset_i) begin
				count_q <= '0;
				ctrl_q <= '0;
				tick_q <= 1'b0;
			end else begin
				tick_q <= expire;
				if (load) begin
					count_q <= bus.dat_w[TIMER_W-1:0];
				end else if (expire && ctrl_q[AUTO]) begin
					count_q <= reload_q;
				end else if (ctrl_q[EN] && count_q != '0) begin
					count_q <= count_q - 1'b1;
				end
				// one-shot mode clears its own enable at zero
				if (sel_ch && reg_sel == mpu_periph_pkg::CONTROL) begin
					ctrl_q <= bus.dat_w[CTW-1:0];
				end else if (expire && !ctrl_q[AUTO]) begin
					ctrl_q[EN] <= 1'b0;
				end
			end
		end

		assign reload_v[ch] = reload_q;
		assign count_v[ch] = count_q;
		assign ctrl_v[ch] = ctrl_q;
		assign tick_o[ch] = tick_q;
	end

	// ======================================
	// read back and ack
	// ======================================

	always_comb begin
		rd_dat = '0;
		case (reg_sel)
			mpu_periph_pkg::RELOAD: rd_dat[TIMER_W-1:0] = reload_v[chan];
			// live count
			mpu_periph_pkg::COUNT: rd_dat[TIMER_W-1:0] = count_v[chan];
			mpu_periph_pkg::CONTROL: rd_dat[CTW-1:0] = ctrl_v[chan];
			default: rd_dat = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
			dat_r_q <= '0;
		end else begin
			ack_q <= req & ~ack_q;
			dat_r_q <= (req & ~ack_q) ? rd_dat : '0;
		end
	end

	assign bus.ack = ack_q;
	assign bus.dat_r = dat_r_q;

endmodule

`default_nettype wire

// File: logic/mpu_bus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_bus_bridge (
	input  logic clk_i,
	input  logic reset_i,
	// core side
	input  logic core_cyc_i,
	input  logic core_stb_i,
	input  logic core_we_i,
	input  logic [mpu_bus_pkg::CORE_SEL_W-1:0] core_sel_i,
	input  logic [mpu_bus_pkg::ADDR_W-1:0] core_adr_i,
	input  logic [mpu_bus_pkg::CORE_DATA_W-1:0] core_dat_i,
	output logic core_ack_o,
	output logic [mpu_bus_pkg::CORE_DATA_W-1:0] core_dat_o,
	// external bus
	output logic ext_cyc_o,
	output logic ext_stb_o,
	output logic ext_we_o,
	output logic [mpu_bus_pkg::CORE_SEL_W-1:0] ext_sel_o,
	output logic [mpu_bus_pkg::ADDR_W-1:0] ext_adr_o,
	output logic [mpu_bus_pkg::CORE_DATA_W-1:0] ext_dat_o,
	input  logic ext_ack_i,
	input  logic [mpu_bus_pkg::CORE_DATA_W-1:0] ext_dat_i,
	// on-chip peripherals
	periph_bus_if.bridge timer_bus,
	periph_bus_if.bridge pic_bus
);

	localparam int DW = mpu_bus_pkg::PERIPH_DATA_W;
	localparam int AW = mpu_bus_pkg::ADDR_W;
	localparam int PAGE_W = mpu_bus_pkg::PAGE_W;
	localparam int PW = mpu_bus_pkg::PERIPH_ADR_W;
	localparam int LANES = mpu_bus_pkg::LANES;
	localparam int LSW = mpu_bus_pkg::LANE_SEL_W;
	localparam int LIW = mpu_bus_pkg::LANE_IDX_W;
	localparam int LLSB = mpu_bus_pkg::LANE_LSB;

	logic cyc_q;
	logic stb_q;
	logic we_q;
	logic ext_stb_q;
	logic timer_cs_q;
	logic pic_cs_q;
	logic hold_q;
	logic [mpu_bus_pkg::CORE_SEL_W-1:0] sel_q;
	logic [AW-1:0] adr_q;
	logic [mpu_bus_pkg::CORE_DATA_W-1:0] dat_q;
	logic timer_hit;
	logic pic_hit;
	logic ack_any;
	logic [LANES-1:0] lane_hot;
	logic [LIW-1:0] lane_idx;
	logic [DW-1:0] lane_dat;
	logic [PW-1:0] periph_adr;

	// ======================================
	// page decode and outbound registers
	// ======================================

	assign timer_hit = core_adr_i[AW-1 -: PAGE_W] == mpu_bus_pkg::TIMER_BASE;
	assign pic_hit = core_adr_i[AW-1 -: PAGE_W] == mpu_bus_pkg::PIC_BASE;
	assign ack_any = ext_ack_i | timer_bus.ack | pic_bus.ack;

	// stb drops on the ack and stays low until the core releases its stb,
	// so a held request is never issued twice
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			cyc_q <= 1'b0;
			stb_q <= 1'b0;
			we_q <= 1'b0;
			ext_stb_q <= 1'b0;
			timer_cs_q <= 1'b0;
			pic_cs_q <= 1'b0;
			hold_q <= 1'b0;
		end else begin
			cyc_q <= core_cyc_i;
			stb_q <= core_stb_i & ~ack_any & ~hold_q;
			we_q <= core_we_i;
			// external stb never shows for an on-chip page
			ext_stb_q <= core_stb_i & ~ack_any & ~hold_q & ~(timer_hit | pic_hit);
			timer_cs_q <= timer_hit;
			pic_cs_q <= pic_hit;
			if (!core_stb_i) begin
				hold_q <= 1'b0;
			end else if (ack_any) begin
				hold_q <= 1'b1;
			end
		end
	end

	// payload
	always_ff @(posedge clk_i) begin
		sel_q <= core_sel_i;
		adr_q <= core_adr_i;
		dat_q <= core_dat_i;
	end

	assign ext_cyc_o = cyc_q;
	assign ext_stb_o = ext_stb_q;
	assign ext_we_o = we_q;
	assign ext_sel_o = sel_q;
	assign ext_adr_o = adr_q;
	assign ext_dat_o = dat_q;

	// ======================================
	// lane narrowing
	// ======================================

	// highest lane with any select wins, lane 0 if none
	always_comb begin
		lane_hot = '0;
		lane_idx = '0;
		lane_dat = '0;
		for (int l = LANES - 1; l > 0; l--) begin
			if (lane_hot == '0 && |sel_q[l*LSW +: LSW]) begin
				lane_hot[l] = 1'b1;
				lane_idx = LIW'(l);
			end
		end
		if (lane_hot == '0) begin
			lane_hot[0] = 1'b1;
		end
		for (int l = 0; l < LANES; l++) begin
			if (lane_hot[l]) begin
				lane_dat = dat_q[l*DW +: DW];
			end
		end
	end

	// bits 3:2 rebuilt from the chosen lane
	assign periph_adr = {adr_q[PW-1:LLSB+LIW], lane_idx, {LLSB{1'b0}}};

	assign timer_bus.cyc = cyc_q;
	assign timer_bus.stb = stb_q;
	assign timer_bus.we = we_q;
	assign timer_bus.adr = periph_adr;
	assign timer_bus.dat_w = lane_dat;
	assign timer_bus.timer_cs = timer_cs_q;
	assign timer_bus.pic_cs = pic_cs_q;

	assign pic_bus.cyc = cyc_q;
	assign pic_bus.stb = stb_q;
	assign pic_bus.we = we_q;
	assign pic_bus.adr = periph_adr;
	assign pic_bus.dat_w = lane_dat;
	assign pic_bus.timer_cs = timer_cs_q;
	assign pic_bus.pic_cs = pic_cs_q;

	// ======================================
	// response merge
	// ======================================

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			core_ack_o <= 1'b0;
		end else begin
			core_ack_o <= ack_any;
		end
	end

	// peripherals drive zero when idle, external data only counts with its ack
	always_ff @(posedge clk_i) begin
		core_dat_o <= {LANES{timer_bus.dat_r}} | {LANES{pic_bus.dat_r}}
			| (ext_ack_i ? ext_dat_i : '0);
	end

endmodule

`default_nettype wire

// File: logic/periph_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;

	// request side, all registered in the bridge
	logic cyc;
	logic stb;
	logic we;
	logic [mpu_bus_pkg::PERIPH_ADR_W-1:0] adr;
	logic [mpu_bus_pkg::PERIPH_DATA_W-1:0] dat_w;
	// one select per peripheral page
	logic timer_cs;
	logic pic_cs;

	// response side, dat_r is zero while ack is low
	logic [mpu_bus_pkg::PERIPH_DATA_W-1:0] dat_r;
	logic ack;

	modport bridge (output cyc, stb, we, adr, dat_w, timer_cs, pic_cs, input dat_r, ack);

	modport periph (input cyc, stb, we, adr, dat_w, timer_cs, pic_cs, output dat_r, ack);

endinterface

`default_nettype wire

// File: logic/mpu_periph_pkg.sv
`default_nettype none

package mpu_periph_pkg;

	// ======================================
	// interval timer
	// ======================================

	localparam int TIMER_CHANNELS = 4;
	localparam int TIMER_CHAN_W = $clog2(TIMER_CHANNELS);
	// channel number in address bits 5:4
	localparam int TIMER_CHAN_LSB = 4;
	// register select in address bits 3:2
	localparam int TIMER_REG_LSB = 2;
	localparam int TIMER_REG_W = 2;

	// control register bits
	localparam int TIMER_CTRL_ENABLE = 0;
	localparam int TIMER_CTRL_AUTO = 1;
	localparam int TIMER_CTRL_W = 2;

	typedef enum logic [TIMER_REG_W-1:0] {
		RELOAD = 2'd0,
		COUNT = 2'd1,
		CONTROL = 2'd2
	} timer_reg_e;

	// ======================================
	// interrupt controller
	// ======================================

	localparam int IRQ_SOURCES = 32;
	// sources 1 to 28 come from outside the node
	localparam int EXT_IRQ_W = 28;
	localparam int IRQ_LEVEL_W = 3;
	localparam int CAUSE_W = 8;
	// register select in address bits 4:2
	localparam int PIC_REG_LSB = 2;
	localparam int PIC_REG_W = 3;
	// eight 4-bit level fields per LEVEL register
	localparam int LEVEL_FIELDS = 8;
	localparam int LEVEL_FIELD_W = 4;

	typedef enum logic [PIC_REG_W-1:0] {
		PENDING = 3'd0,
		ENABLE = 3'd1,
		LEVEL0 = 3'd2,
		LEVEL1 = 3'd3,
		LEVEL2 = 3'd4,
		LEVEL3 = 3'd5
	} pic_reg_e;

endpackage

`default_nettype wire

// File: logic/mpu_bus_pkg.sv
`default_nettype none

package mpu_bus_pkg;

	// ======================================
	// core side bus
	// ======================================

	// 128-bit data with one select per byte
	localparam int CORE_DATA_W = 128;
	localparam int CORE_SEL_W = 16;
	localparam int ADDR_W = 32;

	// ======================================
	// on-chip peripheral pages
	// ======================================

	localparam int PERIPH_DATA_W = 32;
	// each peripheral owns one 4 KB page
	localparam int PERIPH_ADR_W = 12;
	localparam int PAGE_W = ADDR_W - PERIPH_ADR_W;

	// upper address match per page
	localparam logic [PAGE_W-1:0] TIMER_BASE = 20'hFF960;
	localparam logic [PAGE_W-1:0] PIC_BASE = 20'hFF9C0;

	// lane narrowing helpers
	localparam int LANES = CORE_DATA_W / PERIPH_DATA_W;
	localparam int LANE_SEL_W = CORE_SEL_W / LANES;
	localparam int LANE_IDX_W = $clog2(LANES);
	// lane index lands on address bits 3:2
	localparam int LANE_LSB = 2;

endpackage

`default_nettype wire
